// ==== filelist.f ====
src/cpu_pkg.sv
src/wb_if.sv
src/wb_arbiter.sv
src/wb_ram.sv
src/reg_file.sv
src/alu.sv
src/cpu_core.sv
src/cpu_top.sv
bench/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: wb_cpu64

sources:
  - files:
      - src/cpu_pkg.sv
      - src/wb_if.sv
      - src/wb_arbiter.sv
      - src/wb_ram.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/cpu_core.sv
      - src/cpu_top.sv
  - target: simulation
    files:
      - bench/tb_cpu.sv

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    logic              clk;
    logic              rst;
    logic              run;
    logic              halted;
    logic              host_cyc;
    logic              host_stb;
    logic              host_we;
    logic [ADDR_W-1:0] host_adr;
    logic [DATA_W-1:0] host_dat_w;
    logic [DATA_W-1:0] host_dat_r;
    logic              host_ack;

    // one row per program: code, preloaded words, expected words
    logic [DATA_W-1:0] prog     [5][8];
    int                prog_len [5];
    logic [ADDR_W-1:0] pre_adr  [5][4];
    logic [DATA_W-1:0] pre_val  [5][4];
    int                pre_cnt  [5];
    logic [ADDR_W-1:0] res_adr  [5][4];
    logic [DATA_W-1:0] res_val  [5][4];
    int                res_cnt  [5];
    logic              poll_en  [5];
    logic [ADDR_W-1:0] poll_adr [5];
    logic [DATA_W-1:0] poll_val [5];

    int cycle_count;
    int cycle_limit;
    int error_count;

    cpu_top cpu_top_inst (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .halted     (halted),
        .host_cyc   (host_cyc),
        .host_stb   (host_stb),
        .host_we    (host_we),
        .host_adr   (host_adr),
        .host_dat_w (host_dat_w),
        .host_dat_r (host_dat_r),
        .host_ack   (host_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit)
            begin
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Test failures found");
                $fatal(1, "timeout");
            end
        end
    end

    // opcode 5:0, rs1 8:6, rs2 11:9, rd 14:12, hl 15, value 63:32
    function automatic logic [DATA_W-1:0] instr_word(input logic [5:0] op, input logic [2:0] rd,
        input logic [2:0] rs1, input logic [2:0] rs2, input logic hl, input logic [31:0] imm);
        return {imm, 16'd0, hl, rd, rs2, rs1, op};
    endfunction

    function automatic logic [DATA_W-1:0] marker_word(input logic [ADDR_W-1:0] adr);
        return {24'hA5A5A5, adr, 24'h5A5A5A, ~adr};
    endfunction

    task automatic check_value(input logic [DATA_W-1:0] actual,
        input logic [DATA_W-1:0] expected, input string what);
        if (actual !== expected)
        begin
            error_count = error_count + 1;
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
                expected);
            $display("Test failures found");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic put_instr(input int t, input logic [DATA_W-1:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t] = prog_len[t] + 1;
    endtask

    task automatic preload_word(input int t, input logic [ADDR_W-1:0] adr,
        input logic [DATA_W-1:0] val);
        pre_adr[t][pre_cnt[t]] = adr;
        pre_val[t][pre_cnt[t]] = val;
        pre_cnt[t] = pre_cnt[t] + 1;
    endtask

    task automatic expect_word(input int t, input logic [ADDR_W-1:0] adr,
        input logic [DATA_W-1:0] val);
        res_adr[t][res_cnt[t]] = adr;
        res_val[t][res_cnt[t]] = val;
        res_cnt[t] = res_cnt[t] + 1;
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] v;
        for (int t = 0; t < $size(prog_len); t++)
        begin
            prog_len[t] = 0;
            pre_cnt[t]  = 0;
            res_cnt[t]  = 0;
            poll_en[t]  = 1'b0;
        end
        // add and sub on a full word built by LDI low then LDI high
        put_instr(0, instr_word(LDI, 1, 0, 0, 1'b0, 32'h89AB_CDEF));
        put_instr(0, instr_word(LDI, 1, 0, 0, 1'b1, 32'h0123_4567));
        put_instr(0, instr_word(LDI, 2, 0, 0, 1'b0, 32'hF0F0_1234));
        put_instr(0, instr_word(ADD, 3, 1, 2, 1'b0, 32'd0));
        put_instr(0, instr_word(SUB, 4, 2, 1, 1'b0, 32'd0));
        put_instr(0, instr_word(STORE, 0, 0, 3, 1'b0, 32'h40));
        put_instr(0, instr_word(STORE, 0, 0, 4, 1'b0, 32'h41));
        put_instr(0, instr_word(HALT, 0, 0, 0, 1'b0, 32'd0));
        a = {32'd0, 32'h89AB_CDEF};
        a = {32'h0123_4567, a[31:0]};
        b = {32'd0, 32'hF0F0_1234};
        preload_word(0, 8'h40, marker_word(8'h40));
        preload_word(0, 8'h41, marker_word(8'h41));
        expect_word(0, 8'h40, a + b);
        expect_word(0, 8'h41, b - a);
        // and, xor, or chained so every step shows in the result
        put_instr(1, instr_word(LDI, 1, 0, 0, 1'b0, 32'h4B5A_6978));
        put_instr(1, instr_word(LDI, 1, 0, 0, 1'b1, 32'h0F1E_2D3C));
        put_instr(1, instr_word(LDI, 2, 0, 0, 1'b1, 32'hFF00_F0F0));
        put_instr(1, instr_word(AND, 3, 1, 2, 1'b0, 32'd0));
        put_instr(1, instr_word(XOR, 4, 3, 1, 1'b0, 32'd0));
        put_instr(1, instr_word(OR, 4, 4, 2, 1'b0, 32'd0));
        put_instr(1, instr_word(STORE, 0, 0, 4, 1'b0, 32'h42));
        put_instr(1, instr_word(HALT, 0, 0, 0, 1'b0, 32'd0));
        a = {32'h0F1E_2D3C, 32'h4B5A_6978};
        b = {32'hFF00_F0F0, 32'd0};
        preload_word(1, 8'h42, marker_word(8'h42));
        expect_word(1, 8'h42, ((a & b) ^ a) | b);
        // load through base plus offset, add, store at another offset
        put_instr(2, instr_word(LDI, 1, 0, 0, 1'b0, 32'h90));
        put_instr(2, instr_word(LOAD, 2, 1, 0, 1'b0, 32'h10));
        put_instr(2, instr_word(LDI, 3, 0, 0, 1'b0, 32'h8000_0001));
        put_instr(2, instr_word(ADD, 4, 2, 3, 1'b0, 32'd0));
        put_instr(2, instr_word(STORE, 0, 1, 4, 1'b0, 32'h20));
        put_instr(2, instr_word(HALT, 0, 0, 0, 1'b0, 32'd0));
        v = 64'h0FED_CBA9_8765_4321;
        preload_word(2, 8'h90 + 8'h10, v);
        preload_word(2, 8'h90 + 8'h20, marker_word(8'hB0));
        expect_word(2, 8'h90 + 8'h20, v + {32'd0, 32'h8000_0001});
        // taken branch skips the first store, untaken one keeps the second
        put_instr(3, instr_word(LDI, 1, 0, 0, 1'b0, 32'h55));
        put_instr(3, instr_word(CMPEQ, 1, 1, 1, 1'b0, 32'd0));
        put_instr(3, instr_word(BRF, 0, 1, 0, 1'b0, 32'd4));
        put_instr(3, instr_word(STORE, 0, 0, 1, 1'b0, 32'hC0));
        put_instr(3, instr_word(CMPEQ, 2, 1, 0, 1'b0, 32'd0));
        put_instr(3, instr_word(BRF, 0, 2, 0, 1'b0, 32'd7));
        put_instr(3, instr_word(STORE, 0, 0, 1, 1'b0, 32'hC1));
        put_instr(3, instr_word(HALT, 0, 0, 0, 1'b0, 32'd0));
        preload_word(3, 8'hC0, marker_word(8'hC0));
        preload_word(3, 8'hC1, marker_word(8'hC1));
        expect_word(3, 8'hC0, marker_word(8'hC0));
        expect_word(3, 8'hC1, {32'd0, 32'h55});
        // doubling counter stored every pass until it wraps to zero
        put_instr(4, instr_word(LDI, 2, 0, 0, 1'b1, 32'h0001_0000));
        put_instr(4, instr_word(CMPEQ, 7, 0, 0, 1'b0, 32'd0));
        put_instr(4, instr_word(STORE, 0, 0, 2, 1'b0, 32'hD0));
        put_instr(4, instr_word(ADD, 2, 2, 2, 1'b0, 32'd0));
        put_instr(4, instr_word(CMPEQ, 1, 2, 0, 1'b0, 32'd0));
        put_instr(4, instr_word(BRF, 0, 1, 0, 1'b0, 32'd7));
        put_instr(4, instr_word(BRF, 0, 7, 0, 1'b0, 32'd2));
        put_instr(4, instr_word(HALT, 0, 0, 0, 1'b0, 32'd0));
        v = {32'h0001_0000, 32'd0};
        a = v;
        while (v != '0)
        begin
            a = v;
            v = v + v;
        end
        poll_en[4]  = 1'b1;
        poll_adr[4] = 8'hE0;
        poll_val[4] = 64'h600D_CAFE_1234_5678;
        preload_word(4, 8'hE0, poll_val[4]);
        preload_word(4, 8'hD0, marker_word(8'hD0));
        expect_word(4, 8'hD0, a);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // ack seen at a rising edge, request dropped on that same edge
    task automatic finish_host_cycle(output logic [DATA_W-1:0] data);
        do
        begin
            @(negedge clk);
        end
        while (host_ack !== 1'b1);
        data = host_dat_r;
        @(posedge clk);
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        @(posedge clk);
        host_cyc   <= 1'b1;
        host_stb   <= 1'b1;
        host_we    <= 1'b1;
        host_adr   <= adr;
        host_dat_w <= data;
        finish_host_cycle(unused);
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        host_cyc <= 1'b1;
        host_stb <= 1'b1;
        host_we  <= 1'b0;
        host_adr <= adr;
        finish_host_cycle(data);
    endtask

    task automatic compare_results(input int t);
        logic [DATA_W-1:0] got;
        for (int i = 0; i < res_cnt[t]; i++)
        begin
            host_read(res_adr[t][i], got);
            check_value(got, res_val[t][i],
                $sformatf("program %0d, word at %h", t, res_adr[t][i]));
        end
    endtask

    task automatic run_entry(input int t);
        logic [DATA_W-1:0] got;
        logic              poll_done;
        int                polls;
        @(posedge clk);
        run <= 1'b0;
        apply_reset();
        for (int i = 0; i < pre_cnt[t]; i++)
            host_write(pre_adr[t][i], pre_val[t][i]);
        for (int i = 0; i < prog_len[t]; i++)
            host_write(i, prog[t][i]);
        @(posedge clk);
        run <= 1'b1;
        if (poll_en[t])
        begin
            polls     = 0;
            poll_done = 1'b0;
            while (!poll_done)
            begin
                host_read(poll_adr[t], got);
                check_value(got, poll_val[t], $sformatf("host read of %h during run", poll_adr[t]));
                polls = polls + 1;
                @(negedge clk);
                poll_done = halted;
            end
            check_value(polls > 1, 1'b1, "host reads completed while the core ran");
        end
        else
        begin
            do
            begin
                @(negedge clk);
            end
            while (halted !== 1'b1);
        end
        compare_results(t);
        // a halted core must leave memory alone
        repeat (50)
        begin
            @(negedge clk);
            check_value(halted, 1'b1, $sformatf("halted held, program %0d", t));
        end
        compare_results(t);
    endtask

    initial
    begin
        logic [ADDR_W-1:0] rnd_adr [8];
        logic [DATA_W-1:0] rnd_dat [8];
        logic [DATA_W-1:0] got;
        int                total_instr;
        rst         = 1'b1;
        run         = 1'b0;
        host_cyc    = 1'b0;
        host_stb    = 1'b0;
        host_we     = 1'b0;
        host_adr    = '0;
        host_dat_w  = '0;
        error_count = 0;
        void'($urandom(32'haea5));
        build_table();
        total_instr = 0;
        for (int t = 0; t < $size(prog_len); t++)
            total_instr = total_instr + prog_len[t];
        cycle_limit = 60 * total_instr + 2000;
        apply_reset();
        // one random address in each 16-word slice keeps them distinct
        for (int i = 0; i < 8; i++)
        begin
            rnd_adr[i] = 128 + i * 16 + $urandom % 16;
            rnd_dat[i] = {$urandom, $urandom};
            host_write(rnd_adr[i], rnd_dat[i]);
        end
        for (int i = 0; i < 8; i++)
        begin
            host_read(rnd_adr[i], got);
            check_value(got, rnd_dat[i], $sformatf("host read-back at %h", rnd_adr[i]));
        end
        for (int t = 0; t < $size(prog_len); t++)
            run_entry(t);
        if (error_count == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run,
    output logic                       halted,
    input  logic                       host_cyc,
    input  logic                       host_stb,
    input  logic                       host_we,
    input  logic [cpu_pkg::ADDR_W-1:0] host_adr,
    input  logic [cpu_pkg::DATA_W-1:0] host_dat_w,
    output logic [cpu_pkg::DATA_W-1:0] host_dat_r,
    output logic                       host_ack
);

    wb_if host_bus ();
    wb_if core_bus ();
    wb_if ram_bus ();

    assign host_bus.cyc   = host_cyc;
    assign host_bus.stb   = host_stb;
    assign host_bus.we    = host_we;
    assign host_bus.adr   = host_adr;
    assign host_bus.dat_w = host_dat_w;
    assign host_dat_r     = host_bus.dat_r;
    assign host_ack       = host_bus.ack;

    wb_arbiter wb_arbiter_inst (
        .clk  (clk),
        .rst  (rst),
        .host (host_bus.slave),
        .core (core_bus.slave),
        .ram  (ram_bus.master)
    );

    wb_ram wb_ram_inst (
        .clk (clk),
        .bus (ram_bus.slave)
    );

    cpu_core cpu_core_inst (
        .clk    (clk),
        .rst    (rst),
        .run    (run),
        .bus    (core_bus.master),
        .halted (halted)
    );

endmodule

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic clk,
    input  logic rst,
    input  logic run,
    wb_if.master bus,
    output logic halted
);
    import cpu_pkg::*;

    core_state_e       state;
    logic [ADDR_W-1:0] pc;
    instr_u            ir;
    opcode_e           op;
    logic              mem_op;
    logic              reg_op;
    logic [2:0]        rd_a_sel;
    logic [2:0]        rd_b_sel;
    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    logic              fl_out;
    logic              wr_en;
    logic [2:0]        wr_sel;
    logic [DATA_W-1:0] wr_data;
    logic              fl_wr_en;
    logic [DATA_W-1:0] alu_result;
    logic              eq_flag;
    logic [31:0]       imm;

    assign op     = ir.alu_view.opcode;
    assign mem_op = (op == LOAD) || (op == STORE);
    assign reg_op = op inside {ADD, SUB, AND, OR, XOR, LDI};

    // LDI borrows the second read port for the old destination value
    assign rd_a_sel = mem_op ? ir.mem_view.base : ir.alu_view.rs1;
    assign rd_b_sel = (op == STORE) ? ir.mem_view.src :
                      (op == LDI)   ? ir.alu_view.rd  : ir.alu_view.rs2;
    assign imm      = mem_op ? ir.mem_view.offset : ir.alu_view.imm;

    assign wr_en    = ((state == EXEC) && reg_op) ||
                      ((state == MEM) && bus.ack && (op == LOAD));
    assign wr_sel   = (state == MEM) ? ir.mem_view.dst : ir.alu_view.rd;
    assign wr_data  = (state == MEM) ? bus.dat_r : alu_result;
    assign fl_wr_en = (state == EXEC) && (op == CMPEQ);

    reg_file reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .rd_a_sel   (rd_a_sel),
        .rd_b_sel   (rd_b_sel),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .fl_sel     (ir.alu_view.rs1),
        .fl_out     (fl_out),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .fl_wr_en   (fl_wr_en),
        .fl_wr_data (eq_flag)
    );

    alu alu_inst (
        .op       (op),
        .a        (rd_a),
        .b        (rd_b),
        .dest_old (rd_b),
        .imm      (imm),
        .hl       (ir.alu_view.hl),
        .result   (alu_result),
        .eq_flag  (eq_flag)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= FETCH;
            pc      <= '0;
            bus.cyc <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH:
                begin
                    if (bus.cyc)
                    begin
                        if (bus.ack)
                        begin
                            bus.cyc <= 1'b0;
                            state   <= EXEC;
                        end
                    end
                    else if (run)
                        bus.cyc <= 1'b1;
                end
                EXEC:
                begin
                    if (op == HALT)
                        state <= HALTED;
                    else if (mem_op)
                    begin
                        bus.cyc <= 1'b1;
                        state   <= MEM;
                    end
                    else
                    begin
                        if ((op == BRF) && fl_out)
                            pc <= ir.alu_view.imm[ADDR_W-1:0];
                        else
                            pc <= pc + 1'b1;
                        state <= FETCH;
                    end
                end
                MEM:
                begin
                    if (bus.ack)
                    begin
                        bus.cyc <= 1'b0;
                        pc      <= pc + 1'b1;
                        state   <= FETCH;
                    end
                end
                default:
                    state <= HALTED;
            endcase
        end
    end

    // request fields, only meaningful while cyc is high
    always_ff @(posedge clk)
    begin
        if ((state == FETCH) && !bus.cyc)
        begin
            bus.adr <= pc;
            bus.we  <= 1'b0;
        end
        if ((state == FETCH) && bus.ack)
            ir <= bus.dat_r;
        if ((state == EXEC) && mem_op)
        begin
            bus.adr   <= alu_result[ADDR_W-1:0];
            bus.we    <= (op == STORE);
            bus.dat_w <= rd_b;
        end
    end

    assign bus.stb = bus.cyc;
    assign halted  = (state == HALTED);

    a_cyc_until_ack: assert property (@(posedge clk) disable iff (rst)
        bus.cyc && !bus.ack |=> bus.cyc);

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_e           op,
    input  logic [cpu_pkg::DATA_W-1:0] a,
    input  logic [cpu_pkg::DATA_W-1:0] b,
    input  logic [cpu_pkg::DATA_W-1:0] dest_old,
    input  logic [31:0]                imm,
    input  logic                       hl,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic                       eq_flag
);
    import cpu_pkg::*;

    always_comb
    begin
        case (op)
            ADD:
                result = a + b;
            SUB:
                result = a - b;
            AND:
                result = a & b;
            OR:
                result = a | b;
            XOR:
                result = a ^ b;
            LDI:
            begin
                // high half keeps the old low word, low half clears the top
                if (hl)
                    result = {imm, dest_old[31:0]};
                else
                    result = {32'd0, imm};
            end
            LOAD, STORE:
                result = a + {32'd0, imm};
            default:
                result = '0;
        endcase
    end

    assign eq_flag = (a == b);

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [2:0]                rd_a_sel,
    input  logic [2:0]                rd_b_sel,
    output logic [cpu_pkg::DATA_W-1:0] rd_a,
    output logic [cpu_pkg::DATA_W-1:0] rd_b,
    input  logic [2:0]                fl_sel,
    output logic                      fl_out,
    input  logic                      wr_en,
    input  logic [2:0]                wr_sel,
    input  logic [cpu_pkg::DATA_W-1:0] wr_data,
    input  logic                      fl_wr_en,
    input  logic                      fl_wr_data
);
    import cpu_pkg::*;

    logic [DATA_W-1:0]   regs [NUM_REGS];
    logic [NUM_REGS-1:0] flags;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (wr_en)
                regs[wr_sel] <= wr_data;
            // flags share the destination index with the registers
            if (fl_wr_en)
                flags[wr_sel] <= fl_wr_data;
        end
    end

    assign rd_a   = regs[rd_a_sel];
    assign rd_b   = regs[rd_b_sel];
    assign fl_out = flags[fl_sel];

endmodule

// ==== src/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram (
    input logic clk,
    wb_if.slave bus
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              req;

    // a held request after ack counts as a new one only after a gap cycle
    assign req = bus.cyc & bus.stb & ~bus.ack;

    always_ff @(posedge clk)
    begin
        bus.ack <= req;
    end

    always_ff @(posedge clk)
    begin
        if (req && bus.we)
        begin
            mem[bus.adr] <= bus.dat_w;
        end
        bus.dat_r <= mem[bus.adr];
    end

    a_ack_req: assert property (@(posedge clk)
        $rose(bus.ack) |-> $past(bus.cyc && bus.stb));

endmodule

// ==== src/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input logic clk,
    input logic rst,
    wb_if.slave host,
    wb_if.slave core,
    wb_if.master ram
);

    logic gnt_host;
    logic gnt_core;
    logic last_core;
    logic gnt_cyc;
    logic pick_core;

    // core wins when alone, or when both ask and host was served last
    assign pick_core = core.cyc && (!host.cyc || !last_core);

    assign gnt_cyc = (gnt_host & host.cyc) | (gnt_core & core.cyc);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            gnt_host  <= 1'b0;
            gnt_core  <= 1'b0;
            last_core <= 1'b0;
        end
        else if (!gnt_host && !gnt_core)
        begin
            if (host.cyc || core.cyc)
            begin
                gnt_host  <= !pick_core;
                gnt_core  <= pick_core;
                last_core <= pick_core;
            end
        end
        else if (!gnt_cyc)
        begin
            gnt_host <= 1'b0;
            gnt_core <= 1'b0;
        end
    end

    assign ram.cyc   = gnt_cyc;
    assign ram.stb   = (gnt_host & host.stb) | (gnt_core & core.stb);
    assign ram.we    = gnt_core ? core.we : host.we;
    assign ram.adr   = gnt_core ? core.adr : host.adr;
    assign ram.dat_w = gnt_core ? core.dat_w : host.dat_w;

    // read data may go to both, only the granted side gets ack
    assign host.dat_r = ram.dat_r;
    assign core.dat_r = ram.dat_r;
    assign host.ack   = ram.ack & gnt_host;
    assign core.ack   = ram.ack & gnt_core;

    a_hold_host: assert property (@(posedge clk) disable iff (rst)
        gnt_host && host.cyc |=> gnt_host);

    a_hold_core: assert property (@(posedge clk) disable iff (rst)
        gnt_core && core.cyc |=> gnt_core);

    // an ack from the RAM always lands on a master that still holds the grant
    a_ack_granted: assert property (@(posedge clk) disable iff (rst)
        ram.ack |-> (gnt_host && host.cyc) || (gnt_core && core.cyc));

endmodule

// ==== src/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;
    import cpu_pkg::*;

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    localparam int DATA_W    = 64;
    localparam int MEM_WORDS = 256;
    localparam int ADDR_W    = 8;
    localparam int NUM_REGS  = 8;

    // unlisted codes fall through as no-ops
    typedef enum logic [5:0] {
        ADD   = 6'd0,
        SUB   = 6'd1,
        AND   = 6'd2,
        OR    = 6'd3,
        XOR   = 6'd4,
        LDI   = 6'd5,
        LOAD  = 6'd6,
        STORE = 6'd7,
        CMPEQ = 6'd8,
        BRF   = 6'd9,
        HALT  = 6'd63
    } opcode_e;

    typedef struct packed {
        logic [31:0] imm;
        logic [15:0] spare;
        logic        hl;
        logic [2:0]  rd;
        logic [2:0]  rs2;
        logic [2:0]  rs1;
        opcode_e     opcode;
    } alu_view_t;

    // same word as seen by LOAD and STORE
    typedef struct packed {
        logic [31:0] offset;
        logic [16:0] spare;
        logic [2:0]  dst;
        logic [2:0]  src;
        logic [2:0]  base;
        opcode_e     opcode;
    } mem_view_t;

    typedef union packed {
        alu_view_t alu_view;
        mem_view_t mem_view;
    } instr_u;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } core_state_e;

endpackage
